// File: logic/idli_ex_pkg.sv
package idli_ex_pkg;

  // Width of one serial slice, of a full register, and the slice count per word.
  localparam int unsigned SLICE_W    = 4;
  localparam int unsigned WORD_W     = 16;
  localparam int unsigned NUM_SLICES = WORD_W / SLICE_W;

  // One slice of data as it moves through the datapath.
  typedef logic [SLICE_W-1:0] slice_t;

  // Slice counter. Slice 0 holds the least significant bits of a word.
  typedef logic [$clog2(NUM_SLICES)-1:0] ctr_t;

  // Register index.
  typedef logic [3:0] reg_t;

  // The zero register always reads zero, and writes to it are dropped.
  localparam reg_t REG_ZR = 4'd0;

  // Opcodes live in the top nibble of every instruction word.
  typedef enum logic [3:0] {
    OP_ADD    = 4'd0,
    OP_SUB    = 4'd1,
    OP_AND    = 4'd2,
    OP_OR     = 4'd3,
    OP_XOR    = 4'd4,
    OP_SHL    = 4'd5,
    OP_SRL    = 4'd6,
    OP_SRA    = 4'd7,
    OP_LDI    = 4'd8,
    OP_CMPEQ  = 4'd9,
    OP_CMPLT  = 4'd10,
    OP_CMPLTU = 4'd11,
    OP_COND   = 4'd12,
    OP_NOP    = 4'd15
  } op_t;

  // Conditional execution mask. Bit 0 is the P value the next instruction needs.
  typedef logic [7:0] cond_t;

  // Register form of an instruction.
  typedef struct packed {
    op_t  op;
    reg_t dst;
    reg_t lhs;
    reg_t rhs;
  } enc_alu_t;

  // COND form of an instruction. The middle nibble carries nothing.
  typedef struct packed {
    op_t        op;
    logic [3:0] rsvd;
    cond_t      mask;
  } enc_cond_t;

  // Both views of one instruction word share the op field.
  typedef union packed {
    enc_alu_t  alu;
    enc_cond_t cond;
  } enc_u;

  // Decoded control for the instruction that is executing.
  typedef struct packed {
    op_t        op;
    reg_t       dst;
    reg_t       lhs;
    reg_t       rhs;
    logic [7:0] imm;
    logic       is_arith;
    logic       is_shift;
    logic       is_cmp;
    logic       wr_reg;
    logic       is_cond;
    cond_t      mask;
    logic       vld;
  } ctl_t;

endpackage

// File: logic/idli_ex_decode.sv
`timescale 1ns/10ps

module idli_ex_decode (
  input  var logic               i_ex_gck,
  input  var logic               i_ex_rst_n,
  input  var idli_ex_pkg::ctr_t  i_ex_ctr,
  input  var idli_ex_pkg::enc_u  i_ex_enc,
  input  var logic               i_ex_enc_vld,
  output var idli_ex_pkg::ctl_t  o_ex_ctl
);

  import idli_ex_pkg::*;

  // Encoding of the instruction that is executing.
  enc_u enc_q;
  logic vld_q;

  // The valid bit is control state, so it alone sees the reset.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      vld_q <= 1'b0;
    end else if (i_ex_ctr == ctr_t'(NUM_SLICES - 1)) begin
      vld_q <= i_ex_enc_vld;
    end
  end

  // A new word is taken on the edge that closes the last slice. It then holds
  // for all four slices of execution.
  always_ff @(posedge i_ex_gck) begin
    if (i_ex_ctr == ctr_t'(NUM_SLICES - 1)) begin
      enc_q <= i_ex_enc;
    end
  end

  // Register fields come from the register view and the mask from the COND
  // view. Only the flags tell the later stages which of them matter.
  always_comb begin
    o_ex_ctl      = '0;
    o_ex_ctl.op   = enc_q.alu.op;
    o_ex_ctl.dst  = enc_q.alu.dst;
    o_ex_ctl.lhs  = enc_q.alu.lhs;
    o_ex_ctl.rhs  = enc_q.alu.rhs;
    // LDI packs its byte into the two source fields, the lhs field on top.
    o_ex_ctl.imm  = {enc_q.alu.lhs, enc_q.alu.rhs};
    o_ex_ctl.mask = enc_q.cond.mask;
    o_ex_ctl.vld  = vld_q;

    case (enc_q.alu.op)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
        o_ex_ctl.is_arith = 1'b1;
        o_ex_ctl.wr_reg   = 1'b1;
      end
      OP_SHL, OP_SRL, OP_SRA: begin
        o_ex_ctl.is_shift = 1'b1;
        o_ex_ctl.wr_reg   = 1'b1;
      end
      OP_LDI: begin
        o_ex_ctl.wr_reg   = 1'b1;
      end
      OP_CMPEQ, OP_CMPLT, OP_CMPLTU: begin
        // Compares run a subtract through the ALU and write only P.
        o_ex_ctl.is_arith = 1'b1;
        o_ex_ctl.is_cmp   = 1'b1;
      end
      OP_COND: begin
        o_ex_ctl.is_cond  = 1'b1;
      end
      default: begin
        // Unused opcodes behave as NOP.
        o_ex_ctl.op       = OP_NOP;
      end
    endcase
  end

endmodule

// File: logic/idli_ex_rf.sv
`timescale 1ns/10ps

module idli_ex_rf (
  input  var logic                 i_ex_gck,
  input  var idli_ex_pkg::ctr_t    i_ex_ctr,
  input  var idli_ex_pkg::reg_t    i_ex_lhs,
  input  var idli_ex_pkg::reg_t    i_ex_rhs,
  output var idli_ex_pkg::slice_t  o_ex_lhs_data,
  output var idli_ex_pkg::slice_t  o_ex_rhs_data,
  output var logic                 o_ex_lhs_next,
  output var logic                 o_ex_lhs_prev,
  input  var logic                 i_ex_wr,
  input  var idli_ex_pkg::reg_t    i_ex_wr_reg,
  input  var idli_ex_pkg::slice_t  i_ex_wr_data
);

  import idli_ex_pkg::*;

  // Sixteen full words. Contents are undefined until written.
  logic [WORD_W-1:0] regs_q [16];

  // Whole source words with the zero register forced to zero.
  logic [WORD_W-1:0] lhs_word;
  logic [WORD_W-1:0] rhs_word;

  // Top bit of the lhs slice from the cycle before.
  logic prev_q;

  always_comb begin
    lhs_word = (i_ex_lhs == REG_ZR) ? '0 : regs_q[i_ex_lhs];
    rhs_word = (i_ex_rhs == REG_ZR) ? '0 : regs_q[i_ex_rhs];
  end

  // The counter picks which slice of each word is presented.
  always_comb begin
    o_ex_lhs_data = lhs_word[i_ex_ctr*SLICE_W +: SLICE_W];
    o_ex_rhs_data = rhs_word[i_ex_ctr*SLICE_W +: SLICE_W];
  end

  // The bit above the slice has not been overwritten yet, so it comes from
  // the array. Past the top slice the word's own top bit is repeated.
  always_comb begin
    if (i_ex_ctr == ctr_t'(NUM_SLICES - 1)) begin
      o_ex_lhs_next = lhs_word[WORD_W-1];
    end else begin
      o_ex_lhs_next = lhs_word[i_ex_ctr*SLICE_W + SLICE_W];
    end
  end

  // The slice below may already hold this instruction's own result when the
  // destination equals the source. Holding the bit as it was read keeps the
  // old value. Slice 0 has nothing below it.
  always_ff @(posedge i_ex_gck) begin
    prev_q <= o_ex_lhs_data[SLICE_W-1];
  end

  always_comb o_ex_lhs_prev = (i_ex_ctr == '0) ? 1'b0 : prev_q;

  // One slice lands per cycle, at the position named by the counter.
  always_ff @(posedge i_ex_gck) begin
    if (i_ex_wr) begin
      regs_q[i_ex_wr_reg][i_ex_ctr*SLICE_W +: SLICE_W] <= i_ex_wr_data;
    end
  end

endmodule

// File: logic/idli_ex_alu.sv
`timescale 1ns/10ps

module idli_ex_alu (
  input  var logic                 i_ex_gck,
  input  var idli_ex_pkg::ctr_t    i_ex_ctr,
  input  var idli_ex_pkg::ctl_t    i_ex_ctl,
  input  var idli_ex_pkg::slice_t  i_ex_lhs,
  input  var idli_ex_pkg::slice_t  i_ex_rhs,
  output var idli_ex_pkg::slice_t  o_ex_out,
  output var logic                 o_ex_z,
  output var logic                 o_ex_n,
  output var logic                 o_ex_c,
  output var logic                 o_ex_v
);

  import idli_ex_pkg::*;

  logic             sub;
  slice_t           rhs_eff;
  logic             cin;
  logic [SLICE_W:0] sum;

  // Carry and running zero flag handed from one slice to the next.
  logic carry_q;
  logic zero_q;

  // Subtract is add with an inverted rhs and a carry in of one on slice 0.
  always_comb begin
    sub     = (i_ex_ctl.op == OP_SUB) || i_ex_ctl.is_cmp;
    rhs_eff = sub ? ~i_ex_rhs : i_ex_rhs;
    cin     = (i_ex_ctr == '0) ? sub : carry_q;
    sum     = {1'b0, i_ex_lhs} + {1'b0, rhs_eff} + {{SLICE_W{1'b0}}, cin};
  end

  always_comb begin
    case (i_ex_ctl.op)
      OP_AND:  o_ex_out = i_ex_lhs & i_ex_rhs;
      OP_OR:   o_ex_out = i_ex_lhs | i_ex_rhs;
      OP_XOR:  o_ex_out = i_ex_lhs ^ i_ex_rhs;
      default: o_ex_out = sum[SLICE_W-1:0];
    endcase
  end

  // Z covers every slice so far. N, C and V only mean something on the top
  // slice, which is where writeback samples them.
  always_comb begin
    o_ex_z = ((i_ex_ctr == '0) || zero_q) && (o_ex_out == '0);
    o_ex_n = o_ex_out[SLICE_W-1];
    o_ex_c = sum[SLICE_W];
    o_ex_v = (i_ex_lhs[SLICE_W-1] == rhs_eff[SLICE_W-1])
          && (sum[SLICE_W-1] != i_ex_lhs[SLICE_W-1]);
  end

  // Both are overridden on slice 0, so stale values never leak between
  // instructions.
  always_ff @(posedge i_ex_gck) begin
    carry_q <= sum[SLICE_W];
    zero_q  <= o_ex_z;
  end

endmodule

// File: logic/idli_ex_shift.sv
`timescale 1ns/10ps

module idli_ex_shift (
  input  var idli_ex_pkg::ctr_t    i_ex_ctr,
  input  var idli_ex_pkg::ctl_t    i_ex_ctl,
  input  var idli_ex_pkg::slice_t  i_ex_lhs,
  input  var logic                 i_ex_next,
  input  var logic                 i_ex_prev,
  output var idli_ex_pkg::slice_t  o_ex_out
);

  import idli_ex_pkg::*;

  // Bit that enters the top of the slice on a right shift.
  logic top_in;

  // Within the word the bit comes from the slice above. On the last slice the
  // register file repeats the sign bit, which SRA keeps and SRL replaces by zero.
  always_comb begin
    top_in = i_ex_next;

    if (i_ex_ctr == ctr_t'(NUM_SLICES - 1)) begin
      top_in = (i_ex_ctl.op == OP_SRA) ? i_ex_next : 1'b0;
    end
  end

  // SHL pulls in the top bit of the slice below, which is zero on slice 0.
  always_comb begin
    case (i_ex_ctl.op)
      OP_SHL:         o_ex_out = {i_ex_lhs[SLICE_W-2:0], i_ex_prev};
      OP_SRL, OP_SRA: o_ex_out = {top_in, i_ex_lhs[SLICE_W-1:1]};
      default:        o_ex_out = i_ex_lhs;
    endcase
  end

endmodule

// File: logic/idli_ex_wb.sv
`timescale 1ns/10ps

module idli_ex_wb (
  input  var logic                 i_ex_gck,
  input  var logic                 i_ex_rst_n,
  input  var idli_ex_pkg::ctr_t    i_ex_ctr,
  input  var idli_ex_pkg::ctl_t    i_ex_ctl,
  input  var idli_ex_pkg::slice_t  i_ex_alu_out,
  input  var idli_ex_pkg::slice_t  i_ex_shift_out,
  input  var logic                 i_ex_z,
  input  var logic                 i_ex_n,
  input  var logic                 i_ex_c,
  input  var logic                 i_ex_v,
  output var logic                 o_ex_wr,
  output var idli_ex_pkg::reg_t    o_ex_wr_reg,
  output var idli_ex_pkg::slice_t  o_ex_wr_data,
  output var logic                 o_ex_pred
);

  import idli_ex_pkg::*;

  // Predicate bit and conditional execution mask.
  logic  pred_q;
  cond_t mask_q;

  // High when the current instruction must not take effect.
  logic   skip;
  logic   run;
  logic   pred_d;
  slice_t imm_slice;

  // The mask is live only while some bit above bit 0 is set. Bit 0 then
  // names the P value that lets the instruction run.
  always_comb begin
    skip = (|mask_q[7:1]) && (pred_q != mask_q[0]);
    run  = i_ex_ctl.vld && !skip;
  end

  // LDI places its byte in the two low slices and zero above.
  always_comb begin
    case (i_ex_ctr)
      2'd0:    imm_slice = i_ex_ctl.imm[3:0];
      2'd1:    imm_slice = i_ex_ctl.imm[7:4];
      default: imm_slice = '0;
    endcase
  end

  // Arithmetic and compare results come from the ALU. LDI is the only writer left.
  always_comb begin
    if (i_ex_ctl.is_shift) begin
      o_ex_wr_data = i_ex_shift_out;
    end else if (i_ex_ctl.is_arith) begin
      o_ex_wr_data = i_ex_alu_out;
    end else begin
      o_ex_wr_data = imm_slice;
    end
  end

  // A write to the zero register never reaches the port.
  always_comb begin
    o_ex_wr     = run && i_ex_ctl.wr_reg && (i_ex_ctl.dst != REG_ZR);
    o_ex_wr_reg = i_ex_ctl.dst;
  end

  // Flags are only complete on the top slice.
  always_comb begin
    case (i_ex_ctl.op)
      OP_CMPEQ: pred_d = i_ex_z;
      OP_CMPLT: pred_d = i_ex_n != i_ex_v;
      default:  pred_d = !i_ex_c;
    endcase
  end

  // P and the mask change once per instruction, on its last slice.
  // A skipped COND does not load its mask and only ages the old one.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      pred_q <= 1'b0;
      mask_q <= '0;
    end else if (i_ex_ctl.vld && (i_ex_ctr == ctr_t'(NUM_SLICES - 1))) begin
      if (i_ex_ctl.is_cmp && !skip) begin
        pred_q <= pred_d;
      end

      if (i_ex_ctl.is_cond && !skip) begin
        mask_q <= i_ex_ctl.mask;
      end else begin
        mask_q <= {1'b0, mask_q[7:1]};
      end
    end
  end

  always_comb o_ex_pred = pred_q;

endmodule

// File: logic/idli_ex_core.sv
`timescale 1ns/10ps

module idli_ex_core (
  input  var logic                 i_ex_gck,
  input  var logic                 i_ex_rst_n,
  input  var idli_ex_pkg::ctr_t    i_ex_ctr,
  input  var idli_ex_pkg::enc_u    i_ex_enc,
  input  var logic                 i_ex_enc_vld,
  output var logic                 o_ex_rf_wr,
  output var idli_ex_pkg::reg_t    o_ex_rf_reg,
  output var idli_ex_pkg::slice_t  o_ex_rf_data,
  output var logic                 o_ex_pred
);

  import idli_ex_pkg::*;

  // Decoded control for the instruction that is executing.
  ctl_t ctl;

  // Operand slices and the lhs neighbour bits for the shifter.
  slice_t lhs_data;
  slice_t rhs_data;
  logic   lhs_next;
  logic   lhs_prev;

  // Results of the two slice units.
  slice_t alu_out;
  slice_t shift_out;
  logic   alu_z;
  logic   alu_n;
  logic   alu_c;
  logic   alu_v;

  // The next word is sampled here while the current one executes.
  idli_ex_decode decode_u (
    .i_ex_gck     (i_ex_gck),
    .i_ex_rst_n   (i_ex_rst_n),
    .i_ex_ctr     (i_ex_ctr),
    .i_ex_enc     (i_ex_enc),
    .i_ex_enc_vld (i_ex_enc_vld),
    .o_ex_ctl     (ctl)
  );

  // The write port is fed back from writeback, which also drives the outputs.
  idli_ex_rf rf_u (
    .i_ex_gck      (i_ex_gck),
    .i_ex_ctr      (i_ex_ctr),
    .i_ex_lhs      (ctl.lhs),
    .i_ex_rhs      (ctl.rhs),
    .o_ex_lhs_data (lhs_data),
    .o_ex_rhs_data (rhs_data),
    .o_ex_lhs_next (lhs_next),
    .o_ex_lhs_prev (lhs_prev),
    .i_ex_wr       (o_ex_rf_wr),
    .i_ex_wr_reg   (o_ex_rf_reg),
    .i_ex_wr_data  (o_ex_rf_data)
  );

  idli_ex_alu alu_u (
    .i_ex_gck (i_ex_gck),
    .i_ex_ctr (i_ex_ctr),
    .i_ex_ctl (ctl),
    .i_ex_lhs (lhs_data),
    .i_ex_rhs (rhs_data),
    .o_ex_out (alu_out),
    .o_ex_z   (alu_z),
    .o_ex_n   (alu_n),
    .o_ex_c   (alu_c),
    .o_ex_v   (alu_v)
  );

  // The shifter sees the same lhs slice as the ALU, in the same cycle.
  idli_ex_shift shift_u (
    .i_ex_ctr  (i_ex_ctr),
    .i_ex_ctl  (ctl),
    .i_ex_lhs  (lhs_data),
    .i_ex_next (lhs_next),
    .i_ex_prev (lhs_prev),
    .o_ex_out  (shift_out)
  );

  idli_ex_wb wb_u (
    .i_ex_gck       (i_ex_gck),
    .i_ex_rst_n     (i_ex_rst_n),
    .i_ex_ctr       (i_ex_ctr),
    .i_ex_ctl       (ctl),
    .i_ex_alu_out   (alu_out),
    .i_ex_shift_out (shift_out),
    .i_ex_z         (alu_z),
    .i_ex_n         (alu_n),
    .i_ex_c         (alu_c),
    .i_ex_v         (alu_v),
    .o_ex_wr        (o_ex_rf_wr),
    .o_ex_wr_reg    (o_ex_rf_reg),
    .o_ex_wr_data   (o_ex_rf_data),
    .o_ex_pred      (o_ex_pred)
  );

endmodule

// File: tb/idli_ex_core_asserts.sv
`timescale 1ns/10ps

module idli_ex_core_asserts (
  input var logic               i_ex_gck,
  input var logic               i_ex_rst_n,
  input var idli_ex_pkg::ctr_t  i_ex_ctr,
  input var logic               i_ex_wr,
  input var idli_ex_pkg::reg_t  i_ex_reg
);

  import idli_ex_pkg::*;

  // Decode needs a full slice group after reset before anything can execute.
  property no_write_after_reset;
    @(posedge i_ex_gck)
      $rose(i_ex_rst_n) |-> !i_ex_wr ##1 !i_ex_wr ##1 !i_ex_wr ##1 !i_ex_wr;
  endproperty

  // A write group never starts in the middle of a word.
  property write_starts_at_slice0;
    @(posedge i_ex_gck) disable iff (!i_ex_rst_n)
      (i_ex_wr && (i_ex_ctr != ctr_t'(0))) |-> $past(i_ex_wr);
  endproperty

  // A write group never stops in the middle of a word either.
  property write_ends_at_slice3;
    @(posedge i_ex_gck) disable iff (!i_ex_rst_n)
      (!i_ex_wr && (i_ex_ctr != ctr_t'(0))) |-> !$past(i_ex_wr);
  endproperty

  // The zero register is dropped before the write port.
  property no_zero_reg_write;
    @(posedge i_ex_gck) disable iff (!i_ex_rst_n)
      i_ex_wr |-> (i_ex_reg != REG_ZR);
  endproperty

  reset_quiet_a: assert property (no_write_after_reset)
    else $error("register write within four cycles of reset release");
  group_start_a: assert property (write_starts_at_slice0)
    else $error("register write began after slice 0");
  group_end_a:   assert property (write_ends_at_slice3)
    else $error("register write stopped before slice 3");
  zero_reg_a:    assert property (no_zero_reg_write)
    else $error("register 0 was written");

endmodule

bind idli_ex_core idli_ex_core_asserts asserts0 (
  .i_ex_gck   (i_ex_gck),
  .i_ex_rst_n (i_ex_rst_n),
  .i_ex_ctr   (i_ex_ctr),
  .i_ex_wr    (o_ex_rf_wr),
  .i_ex_reg   (o_ex_rf_reg)
);

// File: tb/idli_ex_core_tb.sv
`timescale 1ns/10ps

module idli_ex_core_tb;

  import idli_ex_pkg::*;

  // What the core should show while one instruction executes.
  typedef struct packed {
    logic        wr;
    reg_t        dst;
    logic [15:0] word;
    logic        pred;
  } exp_t;

  localparam int unsigned HALF_NS    = 10;
  localparam int unsigned MAX_CYCLES = 20000;

  logic   clk;
  logic   rst_n;
  ctr_t   ctr;
  enc_u   enc;
  logic   enc_vld;
  logic   rf_wr;
  reg_t   rf_reg;
  slice_t rf_data;
  logic   pred;

  // Reference state, updated in program order as each word is issued.
  logic [15:0] model_regs [16];
  logic        model_pred;
  cond_t       model_mask;

  // Expectation for the instruction in its execution slot.
  exp_t cur_exp;

  string       test_name;
  int          test_errs;
  int          total_errs;
  int          tests_run;
  int          tests_failed;
  integer      seed;
  logic [31:0] rnd_a;
  logic [31:0] rnd_b;

  // Signed and unsigned edge pairs for the compares.
  logic [15:0] cmp_lhs [6] = '{16'h7FFF, 16'h8000, 16'h0005, 16'h0000, 16'hFFFF, 16'h8000};
  logic [15:0] cmp_rhs [6] = '{16'h8000, 16'h7FFF, 16'h0005, 16'hFFFF, 16'h0000, 16'h8001};

  idli_ex_core dut0 (
    .i_ex_gck     (clk),
    .i_ex_rst_n   (rst_n),
    .i_ex_ctr     (ctr),
    .i_ex_enc     (enc),
    .i_ex_enc_vld (enc_vld),
    .o_ex_rf_wr   (rf_wr),
    .o_ex_rf_reg  (rf_reg),
    .o_ex_rf_data (rf_data),
    .o_ex_pred    (pred)
  );

  always #(HALF_NS) clk = ~clk;

  function automatic enc_u make_alu(op_t op, reg_t d, reg_t l, reg_t r);
    enc_u e;
    e = '0;
    e.alu.op  = op;
    e.alu.dst = d;
    e.alu.lhs = l;
    e.alu.rhs = r;
    return e;
  endfunction

  function automatic enc_u make_cond(cond_t m);
    enc_u e;
    e = '0;
    e.cond.op   = OP_COND;
    e.cond.mask = m;
    return e;
  endfunction

  // Counts one failed check against the running test and the total.
  task automatic note_error();
    test_errs++;
    total_errs++;
  endtask

  // Compares the outputs of one slice with the expectation.
  task automatic check_slice(input ctr_t c);
    logic [3:0] want;
    want = cur_exp.word[c*SLICE_W +: SLICE_W];
    assert (rf_wr == cur_exp.wr) else begin
      $display("[ERROR] %s: write enable expected %0b actual %0b", test_name, cur_exp.wr, rf_wr);
      note_error();
    end
    if (cur_exp.wr) begin
      assert (rf_reg == cur_exp.dst) else begin
        $display("[ERROR] %s: write register expected %0d actual %0d",
                 test_name, cur_exp.dst, rf_reg);
        note_error();
      end
      assert (rf_data == want) else begin
        $display("[ERROR] %s: slice %0d expected %h actual %h", test_name, c, want, rf_data);
        note_error();
      end
    end
    assert (pred == cur_exp.pred) else begin
      $display("[ERROR] %s: predicate expected %0b actual %0b", test_name, cur_exp.pred, pred);
      note_error();
    end
  endtask

  // Applies one word to the reference state. Operands are read before any write.
  task automatic model_exec(input enc_u e, input logic vld, output exp_t x);
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] r;
    logic        wr;
    logic        skip;
    a    = model_regs[e.alu.lhs];
    b    = model_regs[e.alu.rhs];
    r    = 16'h0000;
    wr   = 1'b1;
    skip = (|model_mask[7:1]) && (model_pred != model_mask[0]);
    x      = '0;
    x.pred = model_pred;
    x.dst  = e.alu.dst;
    case (e.alu.op)
      OP_ADD:  r = a + b;
      OP_SUB:  r = a - b;
      OP_AND:  r = a & b;
      OP_OR:   r = a | b;
      OP_XOR:  r = a ^ b;
      OP_SHL:  r = a << 1;
      OP_SRL:  r = a >> 1;
      OP_SRA:  r = {a[15], a[15:1]};
      OP_LDI:  r = {8'h00, e.alu.lhs, e.alu.rhs};
      default: wr = 1'b0;
    endcase
    if (vld) begin
      x.wr   = wr && !skip && (e.alu.dst != REG_ZR);
      x.word = r;
      if (x.wr) begin
        model_regs[e.alu.dst] = r;
      end
      if (!skip && (e.alu.op == OP_CMPEQ)) model_pred = (a == b);
      if (!skip && (e.alu.op == OP_CMPLT)) model_pred = ($signed(a) < $signed(b));
      if (!skip && (e.alu.op == OP_CMPLTU)) model_pred = (a < b);
      if (!skip && (e.alu.op == OP_COND)) begin
        model_mask = e.cond.mask;
      end else begin
        model_mask = model_mask >> 1;
      end
    end
  endtask

  // One four-cycle slot. The previous word executes and is checked while
  // this one is presented in the last cycle.
  task automatic issue(input enc_u e, input logic vld);
    exp_t nxt;
    model_exec(e, vld, nxt);
    for (int c = 0; c < 4; c++) begin
      @(negedge clk);
      ctr = ctr_t'(c);
      if (c == 3) begin
        enc     = e;
        enc_vld = vld;
      end
      // Midway to the rising edge the slice outputs have settled.
      #(HALF_NS / 2);
      check_slice(ctr_t'(c));
    end
    cur_exp = nxt;
  endtask

  task automatic run_op(input op_t op, input reg_t d, input reg_t l, input reg_t r);
    issue(make_alu(op, d, l, r), 1'b1);
  endtask

  task automatic load_byte(input reg_t d, input logic [7:0] v);
    run_op(OP_LDI, d, v[7:4], v[3:0]);
  endtask

  // Builds a full word from two bytes, with register 15 as scratch.
  task automatic load_word(input reg_t d, input logic [15:0] v);
    load_byte(d, v[15:8]);
    for (int i = 0; i < 8; i++) begin
      run_op(OP_SHL, d, d, 4'd0);
    end
    load_byte(4'd15, v[7:0]);
    run_op(OP_OR, d, d, 4'd15);
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  // An empty slot retires the last instruction so its checks count here.
  task automatic finish_test();
    issue(make_alu(OP_NOP, 4'd0, 4'd0, 4'd0), 1'b0);
    tests_run++;
    if (test_errs != 0) begin
      tests_failed++;
    end
    $display("test %s: %s (%0d errors)", test_name, (test_errs == 0) ? "ok" : "failed", test_errs);
  endtask

  initial begin
    int n;
    seed       = 11;
    clk        = 1'b0;
    rst_n      = 1'b0;
    ctr        = '0;
    enc        = '0;
    enc_vld    = 1'b0;
    cur_exp    = '0;
    model_pred = 1'b0;
    model_mask = '0;
    total_errs = 0;
    tests_run  = 0;
    tests_failed = 0;
    test_name  = "reset";
    test_errs  = 0;
    for (int i = 0; i < 16; i++) begin
      model_regs[i] = 16'h0000;
    end
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    start_test("ldi_read");
    load_byte(4'd3, 8'hA5);
    load_byte(4'd4, 8'h5A);
    // The zero register drops this byte and still reads zero below.
    load_byte(4'd0, 8'hFF);
    run_op(OP_OR, 4'd5, 4'd3, 4'd0);
    run_op(OP_XOR, 4'd6, 4'd4, 4'd3);
    finish_test();

    start_test("alu_random");
    for (int i = 0; i < 5; i++) begin
      rnd_a = $random(seed);
      rnd_b = $random(seed);
      // The first pair forces a carry through every slice.
      if (i == 0) begin
        rnd_a = 32'h0000_0FFF;
        rnd_b = 32'h0000_F001;
      end
      load_word(4'd1, rnd_a[15:0]);
      load_word(4'd2, rnd_b[15:0]);
      run_op(OP_ADD, 4'd3, 4'd1, 4'd2);
      run_op(OP_SUB, 4'd3, 4'd1, 4'd2);
      run_op(OP_AND, 4'd3, 4'd1, 4'd2);
      run_op(OP_OR, 4'd3, 4'd1, 4'd2);
      run_op(OP_XOR, 4'd3, 4'd1, 4'd2);
    end
    finish_test();

    start_test("shift_random");
    for (int i = 0; i < 4; i++) begin
      rnd_a = $random(seed);
      // Every other value is negative so SRA has a sign to keep.
      if (i % 2 == 0) begin
        rnd_a[15] = 1'b1;
      end
      load_word(4'd1, rnd_a[15:0]);
      run_op(OP_SHL, 4'd4, 4'd1, 4'd0);
      run_op(OP_SRL, 4'd5, 4'd1, 4'd0);
      run_op(OP_SRA, 4'd6, 4'd1, 4'd0);
      run_op(OP_SRA, 4'd1, 4'd1, 4'd0);
    end
    finish_test();

    start_test("compare_edges");
    for (int i = 0; i < 6; i++) begin
      load_word(4'd1, cmp_lhs[i]);
      load_word(4'd2, cmp_rhs[i]);
      run_op(OP_CMPEQ, 4'd0, 4'd1, 4'd2);
      run_op(OP_CMPLT, 4'd0, 4'd1, 4'd2);
      run_op(OP_CMPLTU, 4'd0, 4'd1, 4'd2);
    end
    finish_test();

    start_test("cond_mask");
    load_byte(4'd1, 8'h05);
    run_op(OP_CMPEQ, 4'd0, 4'd1, 4'd1);
    // Mask 0x06 wants P clear for one word, then P set for the next.
    issue(make_cond(8'h06), 1'b1);
    load_byte(4'd5, 8'h11);
    load_byte(4'd5, 8'h22);
    load_byte(4'd6, 8'h33);
    // A skipped compare must leave P alone.
    issue(make_cond(8'h02), 1'b1);
    run_op(OP_CMPLTU, 4'd0, 4'd0, 4'd1);
    load_byte(4'd7, 8'h44);
    issue(make_cond(8'h03), 1'b1);
    run_op(OP_CMPEQ, 4'd0, 4'd0, 4'd1);
    run_op(OP_OR, 4'd8, 4'd5, 4'd6);
    finish_test();

    start_test("back_to_back");
    load_byte(4'd1, 8'h07);
    run_op(OP_ADD, 4'd2, 4'd1, 4'd1);
    run_op(OP_ADD, 4'd2, 4'd2, 4'd2);
    run_op(OP_SUB, 4'd3, 4'd2, 4'd1);
    run_op(OP_SHL, 4'd3, 4'd3, 4'd0);
    run_op(OP_XOR, 4'd1, 4'd3, 4'd2);
    run_op(OP_SUB, 4'd1, 4'd0, 4'd1);
    run_op(OP_SRA, 4'd1, 4'd1, 4'd0);
    finish_test();

    // Empty slots until the write port goes quiet, bounded.
    n = 0;
    while ((rf_wr !== 1'b0) && (n < 4)) begin
      issue(make_alu(OP_NOP, 4'd0, 4'd0, 4'd0), 1'b0);
      n++;
    end
    if (rf_wr !== 1'b0) begin
      $display("Write enable stayed high after the last instruction retired.");
      total_errs++;
    end

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errs);
    if (total_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Bounds the whole run in clock cycles.
  initial begin : watchdog
    int cycles;
    for (cycles = 0; cycles < MAX_CYCLES; cycles++) begin
      @(posedge clk);
    end
    $display("Timeout: the sequence did not finish within %0d cycles.", MAX_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: idli_ex_core.f
logic/idli_ex_pkg.sv
logic/idli_ex_decode.sv
logic/idli_ex_rf.sv
logic/idli_ex_alu.sv
logic/idli_ex_shift.sv
logic/idli_ex_wb.sv
logic/idli_ex_core.sv
tb/idli_ex_core_asserts.sv
tb/idli_ex_core_tb.sv

// File: Makefile
SIM   := verilator
FLAGS := --binary --timing --assert -j 0
TOP   := idli_ex_core_tb
FLIST := idli_ex_core.f
OBJ   := obj_dir
LOG   := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP) > $(LOG) 2>&1 ; cat $(LOG) ; grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
